// File: design/rvfi_cfg.svh
`ifndef RVFI_CFG_SVH
`define RVFI_CFG_SVH

`define XLEN    32
`define ORDER_W 64
`define COUNT_W 32
`define ERR_W   5

// Error code bit positions
`define ERR_ORDER         0
`define ERR_MASK_CONFLICT 1
`define ERR_MASK_SHAPE    2
`define ERR_X0_WRITE      3
`define ERR_PC_ALIGN      4

// Measurement markers (slti x0 with immediates 1 and 2)
`define INST_START    32'h00102013
`define INST_STOP     32'h00202013

// Self-loop encodings that end a program
`define INST_HALT_BEQ 32'h00000063
`define INST_HALT_JAL 32'h0000006f

`endif

// File: design/rvfi_pkg.sv
`default_nettype none

`include "rvfi_cfg.svh"

package rvfi_pkg;

    // Instruction, PC, register data and memory address
    typedef logic [`XLEN-1:0] word_t;

    typedef logic [`ORDER_W-1:0] order_t;   // Retirement order

    typedef logic [4:0] reg_addr_t;

    // One bit per byte lane of a word
    typedef logic [`XLEN/8-1:0] byte_mask_t;

endpackage

`default_nettype wire

// File: design/mon_pkg.sv
`default_nettype none

`include "rvfi_cfg.svh"

package mon_pkg;

    typedef logic [`ERR_W-1:0]   err_code_t;
    typedef logic [`COUNT_W-1:0] count_t;

    // Memory access kind of a trace record
    typedef logic [1:0] mem_kind_t;

    localparam mem_kind_t MEM_NONE  = 2'd0;
    localparam mem_kind_t MEM_LOAD  = 2'd1;
    localparam mem_kind_t MEM_STORE = 2'd2;

    typedef enum logic [1:0] {
        WIN_IDLE,
        WIN_MEASURE,
        WIN_DONE
    } window_state_e;

endpackage

`default_nettype wire

// File: design/commit_checker.sv
`default_nettype none

`include "rvfi_cfg.svh"

module commit_checker (
    input  wire                      itf,
    input  wire                      rst_n,
    input  wire                      valid,
    input  wire rvfi_pkg::order_t    order,
    input  wire rvfi_pkg::reg_addr_t rd_addr,
    input  wire rvfi_pkg::word_t     rd_wdata,
    input  wire rvfi_pkg::word_t     pc_wdata,
    input  wire rvfi_pkg::byte_mask_t mem_rmask,
    input  wire rvfi_pkg::byte_mask_t mem_wmask,
    output mon_pkg::err_code_t       err_code,
    output logic                     error
);

    rvfi_pkg::order_t   exp_order;   // Order expected from the next commit
    mon_pkg::err_code_t flags;

    // Byte, aligned halfword or full word
    function automatic logic mask_ok(rvfi_pkg::byte_mask_t m);
        case (m)
            4'b0001, 4'b0010, 4'b0100, 4'b1000: return 1'b1;
            4'b0011, 4'b1100, 4'b1111:          return 1'b1;
            default:                            return 1'b0;
        endcase
    endfunction

    always_comb begin
        flags = '0;
        flags[`ERR_ORDER]         = (order != exp_order);
        flags[`ERR_MASK_CONFLICT] = (|mem_rmask) && (|mem_wmask);
        flags[`ERR_MASK_SHAPE]    = ((|mem_rmask) && !mask_ok(mem_rmask)) ||
                                    ((|mem_wmask) && !mask_ok(mem_wmask));
        flags[`ERR_X0_WRITE]      = (rd_addr == '0) && (rd_wdata != '0);
        flags[`ERR_PC_ALIGN]      = pc_wdata[0];
    end

    // Following the observed order resyncs after a skip, so one gap flags once
    always_ff @(posedge itf or negedge rst_n) begin
        if (!rst_n) begin
            exp_order <= '0;
            err_code  <= '0;
        end else if (valid) begin
            exp_order <= order + 1'b1;
            err_code  <= err_code | flags;   // Sticky until reset
        end
    end

    assign error = |err_code;

endmodule

`default_nettype wire

// File: design/run_control.sv
`default_nettype none

`include "rvfi_cfg.svh"

module run_control (
    input  wire                  itf,
    input  wire                  rst_n,
    input  wire                  valid,
    input  wire rvfi_pkg::word_t inst,
    input  wire rvfi_pkg::word_t pc_rdata,
    input  wire rvfi_pkg::word_t pc_wdata,
    output logic                 halt,
    output logic                 measure_done,
    output mon_pkg::count_t      inst_count,
    output mon_pkg::count_t      cycle_count
);

    mon_pkg::window_state_e state;
    mon_pkg::window_state_e state_next;
    logic                   is_start;
    logic                   is_stop;
    logic                   is_halt;

    assign is_start = valid && (inst == `INST_START);
    assign is_stop  = valid && (inst == `INST_STOP);

    // A commit that jumps to itself never leaves
    assign is_halt = valid && ((pc_rdata == pc_wdata) ||
                               (inst == `INST_HALT_BEQ) ||
                               (inst == `INST_HALT_JAL));

    always_comb begin
        state_next = state;
        case (state)
            mon_pkg::WIN_MEASURE: begin
                // A second start keeps measuring and only clears the counters
                if (is_stop) state_next = mon_pkg::WIN_DONE;
            end
            default: begin
                if (is_start) state_next = mon_pkg::WIN_MEASURE;
            end
        endcase
    end

    always_ff @(posedge itf or negedge rst_n) begin
        if (!rst_n) begin
            state       <= mon_pkg::WIN_IDLE;
            halt        <= 1'b0;
            inst_count  <= '0;
            cycle_count <= '0;
        end else begin
            state <= state_next;
            if (is_halt) halt <= 1'b1;
            if (is_start) begin
                inst_count  <= '0;
                cycle_count <= '0;
            end else if (state == mon_pkg::WIN_MEASURE) begin
                // Stop edge still counts and the counters freeze after it
                cycle_count <= cycle_count + 1'b1;
                if (valid) inst_count <= inst_count + 1'b1;
            end
        end
    end

    assign measure_done = (state == mon_pkg::WIN_DONE);

endmodule

`default_nettype wire

// File: design/trace_encoder.sv
`default_nettype none

module trace_encoder (
    input  wire                       itf,
    input  wire                       rst_n,
    input  wire                       valid,
    input  wire rvfi_pkg::word_t      inst,
    input  wire rvfi_pkg::reg_addr_t  rd_addr,
    input  wire rvfi_pkg::word_t      rd_wdata,
    input  wire rvfi_pkg::word_t      pc_rdata,
    input  wire rvfi_pkg::word_t      mem_addr,
    input  wire rvfi_pkg::byte_mask_t mem_rmask,
    input  wire rvfi_pkg::byte_mask_t mem_wmask,
    input  wire rvfi_pkg::word_t      mem_wdata,
    output logic                      trace_valid,
    output rvfi_pkg::word_t           trace_pc,
    output rvfi_pkg::word_t           trace_inst,
    output rvfi_pkg::reg_addr_t       trace_rd_addr,
    output rvfi_pkg::word_t           trace_rd_data,
    output mon_pkg::mem_kind_t        trace_mem_kind,
    output rvfi_pkg::word_t           trace_mem_addr,
    output rvfi_pkg::word_t           trace_store_data
);

    rvfi_pkg::byte_mask_t act_mask;
    mon_pkg::mem_kind_t   kind;
    logic [1:0]           lane;        // Lowest active byte lane
    rvfi_pkg::word_t      shifted;
    rvfi_pkg::word_t      inst_n;
    rvfi_pkg::word_t      addr_n;
    rvfi_pkg::word_t      store_n;

    function automatic logic [1:0] lowest_lane(rvfi_pkg::byte_mask_t m);
        logic [1:0] idx;
        idx = '0;
        for (int i = 3; i >= 0; i--) begin
            if (m[i]) idx = 2'(i);
        end
        return idx;
    endfunction

    // Store wins over load when both masks are set
    assign act_mask = (|mem_wmask) ? mem_wmask : mem_rmask;
    assign kind     = (|mem_wmask) ? mon_pkg::MEM_STORE :
                      (|mem_rmask) ? mon_pkg::MEM_LOAD  : mon_pkg::MEM_NONE;
    assign lane     = lowest_lane(act_mask);
    assign shifted  = mem_wdata >> {lane, 3'b000};

    // Compressed instructions keep only their low halfword
    assign inst_n = (inst[1:0] == 2'b11) ? inst : {16'b0, inst[15:0]};
    assign addr_n = (kind == mon_pkg::MEM_NONE) ? '0 : ({mem_addr[31:2], 2'b00} + lane);

    always_comb begin
        store_n = '0;
        if (kind == mon_pkg::MEM_STORE) begin
            case ($countones(mem_wmask))
                1:       store_n = {24'b0, shifted[7:0]};
                2:       store_n = {16'b0, shifted[15:0]};
                default: store_n = mem_wdata;
            endcase
        end
    end

    always_ff @(posedge itf or negedge rst_n) begin
        if (!rst_n) trace_valid <= 1'b0;
        else        trace_valid <= valid;
    end

    always_ff @(posedge itf) begin
        if (valid) begin
            trace_pc         <= pc_rdata;
            trace_inst       <= inst_n;
            trace_rd_addr    <= rd_addr;
            trace_rd_data    <= (rd_addr == '0) ? '0 : rd_wdata;
            trace_mem_kind   <= kind;
            trace_mem_addr   <= addr_n;
            trace_store_data <= store_n;
        end
    end

endmodule

`default_nettype wire

// File: design/commit_monitor.sv
`default_nettype none

module commit_monitor (
    input  wire                       itf,
    input  wire                       rst_n,
    input  wire                       valid,
    input  wire rvfi_pkg::order_t     order,
    input  wire rvfi_pkg::word_t      inst,
    input  wire rvfi_pkg::reg_addr_t  rd_addr,
    input  wire rvfi_pkg::word_t      rd_wdata,
    input  wire rvfi_pkg::word_t      pc_rdata,
    input  wire rvfi_pkg::word_t      pc_wdata,
    input  wire rvfi_pkg::word_t      mem_addr,
    input  wire rvfi_pkg::byte_mask_t mem_rmask,
    input  wire rvfi_pkg::byte_mask_t mem_wmask,
    input  wire rvfi_pkg::word_t      mem_wdata,
    output mon_pkg::err_code_t        err_code,
    output logic                      error,
    output logic                      halt,
    output logic                      measure_done,
    output mon_pkg::count_t           inst_count,
    output mon_pkg::count_t           cycle_count,
    output logic                      trace_valid,
    output rvfi_pkg::word_t           trace_pc,
    output rvfi_pkg::word_t           trace_inst,
    output rvfi_pkg::reg_addr_t       trace_rd_addr,
    output rvfi_pkg::word_t           trace_rd_data,
    output mon_pkg::mem_kind_t        trace_mem_kind,
    output rvfi_pkg::word_t           trace_mem_addr,
    output rvfi_pkg::word_t           trace_store_data
);

    // All three blocks watch the same commit stream independently
    commit_checker i_commit_checker (
        .itf       (itf),
        .rst_n     (rst_n),
        .valid     (valid),
        .order     (order),
        .rd_addr   (rd_addr),
        .rd_wdata  (rd_wdata),
        .pc_wdata  (pc_wdata),
        .mem_rmask (mem_rmask),
        .mem_wmask (mem_wmask),
        .err_code  (err_code),
        .error     (error)
    );

    run_control i_run_control (
        .itf          (itf),
        .rst_n        (rst_n),
        .valid        (valid),
        .inst         (inst),
        .pc_rdata     (pc_rdata),
        .pc_wdata     (pc_wdata),
        .halt         (halt),
        .measure_done (measure_done),
        .inst_count   (inst_count),
        .cycle_count  (cycle_count)
    );

    trace_encoder i_trace_encoder (
        .itf              (itf),
        .rst_n            (rst_n),
        .valid            (valid),
        .inst             (inst),
        .rd_addr          (rd_addr),
        .rd_wdata         (rd_wdata),
        .pc_rdata         (pc_rdata),
        .mem_addr         (mem_addr),
        .mem_rmask        (mem_rmask),
        .mem_wmask        (mem_wmask),
        .mem_wdata        (mem_wdata),
        .trace_valid      (trace_valid),
        .trace_pc         (trace_pc),
        .trace_inst       (trace_inst),
        .trace_rd_addr    (trace_rd_addr),
        .trace_rd_data    (trace_rd_data),
        .trace_mem_kind   (trace_mem_kind),
        .trace_mem_addr   (trace_mem_addr),
        .trace_store_data (trace_store_data)
    );

endmodule

`default_nettype wire

// File: bench/commit_monitor_assertions.sv
`default_nettype none

module commit_monitor_assertions (
    input wire itf,
    input wire rst_n,
    input wire valid,
    input wire trace_valid,
    input wire error,
    input wire halt
);

    trace_follows_valid: assert property (@(posedge itf) disable iff (!rst_n)
        trace_valid == $past(valid))
        else $error("trace_valid differs from valid of the previous cycle");

    // Both flags are sticky until reset
    error_sticky: assert property (@(posedge itf) disable iff (!rst_n) error |=> error)
        else $error("error fell while out of reset");

    halt_sticky: assert property (@(posedge itf) disable iff (!rst_n) halt |=> halt)
        else $error("halt fell while out of reset");

endmodule

bind commit_monitor commit_monitor_assertions i_commit_monitor_assertions (
    .itf         (itf),
    .rst_n       (rst_n),
    .valid       (valid),
    .trace_valid (trace_valid),
    .error       (error),
    .halt        (halt)
);

`default_nettype wire

// File: bench/commit_monitor_checker.sv
`default_nettype none

`include "rvfi_cfg.svh"

module commit_monitor_checker (
    input wire                       itf, rst_n, valid,
    input wire rvfi_pkg::order_t     order,
    input wire rvfi_pkg::word_t      inst, rd_wdata, pc_rdata, pc_wdata,
    input wire rvfi_pkg::word_t      mem_addr, mem_wdata,
    input wire rvfi_pkg::reg_addr_t  rd_addr,
    input wire rvfi_pkg::byte_mask_t mem_rmask, mem_wmask,
    input wire mon_pkg::err_code_t   err_code,
    input wire                       error, halt, measure_done, trace_valid,
    input wire mon_pkg::count_t      inst_count, cycle_count,
    input wire rvfi_pkg::word_t      trace_pc, trace_inst, trace_rd_data,
    input wire rvfi_pkg::word_t      trace_mem_addr, trace_store_data,
    input wire rvfi_pkg::reg_addr_t  trace_rd_addr,
    input wire mon_pkg::mem_kind_t   trace_mem_kind,
    output int                       error_count
);

    rvfi_pkg::order_t       m_order;                 // Next expected order
    mon_pkg::err_code_t     m_err;
    mon_pkg::window_state_e m_state;
    mon_pkg::count_t        m_insts, m_cycles;
    logic                   m_halt, m_tvalid;
    rvfi_pkg::word_t        m_pc, m_inst, m_rd_data, m_addr, m_store;
    rvfi_pkg::reg_addr_t    m_rd_addr;
    mon_pkg::mem_kind_t     m_kind;
    int                     errs = 0;

    assign error_count = errs;

    function automatic logic bad_shape(rvfi_pkg::byte_mask_t m);
        return (m != 4'h0) && !(m inside {4'h1, 4'h2, 4'h4, 4'h8, 4'h3, 4'hc, 4'hf});
    endfunction

    function automatic rvfi_pkg::word_t lane_of(rvfi_pkg::byte_mask_t m);
        if (m[0]) return 32'd0;
        if (m[1]) return 32'd1;
        if (m[2]) return 32'd2;
        return 32'd3;
    endfunction

    // Size follows the number of active lanes
    function automatic rvfi_pkg::word_t store_value(rvfi_pkg::byte_mask_t m, rvfi_pkg::word_t d);
        rvfi_pkg::word_t v;
        int              n;
        n = 0;
        for (int i = 0; i < 4; i++) begin
            if (m[i]) n++;
        end
        v = d >> (lane_of(m) * 32'd8);
        if (n == 1) return v & 32'h0000_00ff;
        if (n == 2) return v & 32'h0000_ffff;
        return d;
    endfunction

    task automatic compare(string name, logic [63:0] got, logic [63:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
            errs++;
        end
    endtask

    always @(posedge itf or negedge rst_n) begin
        if (!rst_n) begin
            m_order  <= '0;
            m_err    <= '0;
            m_state  <= mon_pkg::WIN_IDLE;
            m_insts  <= '0;
            m_cycles <= '0;
            m_halt   <= 1'b0;
            m_tvalid <= 1'b0;
        end else begin
            m_tvalid <= valid;
            if (valid) begin
                m_order <= order + 64'd1;
                if (order != m_order) m_err[`ERR_ORDER] <= 1'b1;
                if (mem_rmask != 4'h0 && mem_wmask != 4'h0) m_err[`ERR_MASK_CONFLICT] <= 1'b1;
                if (bad_shape(mem_rmask) || bad_shape(mem_wmask)) m_err[`ERR_MASK_SHAPE] <= 1'b1;
                if (rd_addr == 5'd0 && rd_wdata != 32'd0) m_err[`ERR_X0_WRITE] <= 1'b1;
                if (pc_wdata[0]) m_err[`ERR_PC_ALIGN] <= 1'b1;
                if (pc_rdata == pc_wdata || inst == `INST_HALT_BEQ || inst == `INST_HALT_JAL)
                    m_halt <= 1'b1;
                m_pc      <= pc_rdata;
                m_inst    <= (inst[1:0] == 2'b11) ? inst : (inst & 32'h0000_ffff);
                m_rd_addr <= rd_addr;
                m_rd_data <= (rd_addr == 5'd0) ? 32'd0 : rd_wdata;
                if (mem_wmask != 4'h0) begin
                    m_kind  <= 2'd2;
                    m_addr  <= (mem_addr & 32'hffff_fffc) + lane_of(mem_wmask);
                    m_store <= store_value(mem_wmask, mem_wdata);
                end else if (mem_rmask != 4'h0) begin
                    m_kind  <= 2'd1;
                    m_addr  <= (mem_addr & 32'hffff_fffc) + lane_of(mem_rmask);
                    m_store <= 32'd0;
                end else begin
                    m_kind  <= 2'd0;
                    m_addr  <= 32'd0;
                    m_store <= 32'd0;
                end
            end
            if (valid && inst == `INST_START) begin
                m_state  <= mon_pkg::WIN_MEASURE;
                m_insts  <= '0;
                m_cycles <= '0;
            end else if (m_state == mon_pkg::WIN_MEASURE) begin
                m_cycles <= m_cycles + 32'd1;
                if (valid) m_insts <= m_insts + 32'd1;
                if (valid && inst == `INST_STOP) m_state <= mon_pkg::WIN_DONE;
            end
        end
    end

    // Outputs are settled half a cycle after the edge
    always @(negedge itf) begin
        compare("err_code", 64'(err_code), 64'(m_err));
        compare("error", 64'(error), 64'(|m_err));
        compare("halt", 64'(halt), 64'(m_halt));
        compare("measure_done", 64'(measure_done), 64'(m_state == mon_pkg::WIN_DONE));
        compare("inst_count", 64'(inst_count), 64'(m_insts));
        compare("cycle_count", 64'(cycle_count), 64'(m_cycles));
        compare("trace_valid", 64'(trace_valid), 64'(m_tvalid));
        if (m_tvalid) begin
            compare("trace_pc", 64'(trace_pc), 64'(m_pc));
            compare("trace_inst", 64'(trace_inst), 64'(m_inst));
            compare("trace_rd_addr", 64'(trace_rd_addr), 64'(m_rd_addr));
            compare("trace_rd_data", 64'(trace_rd_data), 64'(m_rd_data));
            compare("trace_mem_kind", 64'(trace_mem_kind), 64'(m_kind));
            compare("trace_mem_addr", 64'(trace_mem_addr), 64'(m_addr));
            compare("trace_store_data", 64'(trace_store_data), 64'(m_store));
        end
    end

endmodule

`default_nettype wire

// File: bench/commit_monitor_tb.sv
`default_nettype none

`include "rvfi_cfg.svh"

module commit_monitor_tb;

    localparam int N_RANDOM    = 200;
    localparam int N_COMMITS   = N_RANDOM + 30;   // Markers, faults and fillers
    localparam int MAX_GAP     = 2;
    localparam int STIM_CYCLES = N_COMMITS * (MAX_GAP + 1) + 10;
    localparam int TIMEOUT     = 2 * STIM_CYCLES + 100;

    localparam logic [3:0] SHAPES [8] = '{4'h1, 4'h2, 4'h4, 4'h8, 4'h3, 4'hc, 4'hf, 4'hf};

    logic                 itf, rst_n, valid;
    rvfi_pkg::order_t     order;
    rvfi_pkg::word_t      inst, rd_wdata, pc_rdata, pc_wdata, mem_addr, mem_wdata;
    rvfi_pkg::reg_addr_t  rd_addr;
    rvfi_pkg::byte_mask_t mem_rmask, mem_wmask;
    mon_pkg::err_code_t   err_code;
    logic                 error, halt, measure_done, trace_valid;
    mon_pkg::count_t      inst_count, cycle_count;
    rvfi_pkg::word_t      trace_pc, trace_inst, trace_rd_data, trace_mem_addr, trace_store_data;
    rvfi_pkg::reg_addr_t  trace_rd_addr;
    mon_pkg::mem_kind_t   trace_mem_kind;
    int                   error_count;        // Mismatches seen by the checker
    int                   other_errors = 0;
    int                   cycles;
    logic [31:0]          rng;
    rvfi_pkg::order_t     next_order;
    rvfi_pkg::word_t      cur_pc;

    commit_monitor i_commit_monitor (.*);

    commit_monitor_checker i_commit_monitor_checker (.*);

    initial begin
        itf = 1'b0;
        forever #50 itf = ~itf;
    end

    function automatic logic [31:0] xorshift();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    task automatic send_commit(rvfi_pkg::order_t o, rvfi_pkg::word_t i, rvfi_pkg::reg_addr_t rd,
                               rvfi_pkg::word_t d, rvfi_pkg::word_t pc_w,
                               rvfi_pkg::byte_mask_t rm, rvfi_pkg::byte_mask_t wm);
        int gap;
        @(negedge itf);
        valid      = 1'b1;
        order      = o;
        inst       = i;
        rd_addr    = rd;
        rd_wdata   = d;
        pc_rdata   = cur_pc;
        pc_wdata   = pc_w;
        mem_addr   = xorshift();
        mem_rmask  = rm;
        mem_wmask  = wm;
        mem_wdata  = xorshift();
        next_order = o + 64'd1;     // Follows a skipped order like the DUT does
        cur_pc     = cur_pc + 32'd4;
        gap = int'(xorshift() % (MAX_GAP + 1));
        repeat (gap) begin
            @(negedge itf);
            valid = 1'b0;
        end
    endtask

    task automatic marker_commit(rvfi_pkg::word_t i, logic self_loop);
        send_commit(next_order, i, 5'd0, 32'd0, self_loop ? cur_pc : cur_pc + 32'd4, 4'h0, 4'h0);
    endtask

    // fault is an error bit position, or -1 for a legal commit
    task automatic random_commit(int fault);
        rvfi_pkg::word_t      i;
        rvfi_pkg::word_t      d;
        rvfi_pkg::word_t      pc_w;
        rvfi_pkg::reg_addr_t  rd;
        rvfi_pkg::byte_mask_t rm;
        rvfi_pkg::byte_mask_t wm;
        rvfi_pkg::order_t     o;
        logic [31:0]          r;
        i = xorshift();
        if (i inside {`INST_START, `INST_STOP, `INST_HALT_BEQ, `INST_HALT_JAL}) i = i ^ 32'h100;
        r    = xorshift();
        rd   = r[4:0];
        d    = (rd == 5'd0) ? 32'd0 : xorshift();
        rm   = (r[12:11] == 2'd1) ? SHAPES[r[10:8]] : 4'h0;
        wm   = (r[12:11] == 2'd2) ? SHAPES[r[10:8]] : 4'h0;
        o    = next_order;
        pc_w = cur_pc + 32'd4;
        case (fault)
            `ERR_ORDER:         o = next_order + 64'd7;
            `ERR_MASK_CONFLICT: begin
                rm = 4'h3;
                wm = 4'hc;
            end
            `ERR_MASK_SHAPE: begin
                rm = 4'h0;
                wm = 4'h5;
            end
            `ERR_X0_WRITE: begin
                rd = 5'd0;
                d  = xorshift() | 32'd1;
            end
            `ERR_PC_ALIGN:      pc_w = cur_pc + 32'd3;
            default:            ;
        endcase
        send_commit(o, i, rd, d, pc_w, rm, wm);
    endtask

    initial begin
        rng        = 32'hbc46_3d47;
        rst_n      = 1'b0;
        valid      = 1'b0;
        order      = '0;
        inst       = '0;
        rd_addr    = '0;
        rd_wdata   = '0;
        pc_rdata   = '0;
        pc_wdata   = '0;
        mem_addr   = '0;
        mem_rmask  = '0;
        mem_wmask  = '0;
        mem_wdata  = '0;
        next_order = '0;
        cur_pc     = 32'h0000_1000;
        repeat (4) @(negedge itf);
        rst_n = 1'b1;
        repeat (2) @(negedge itf);   // Idle outputs checked before any commit
        repeat (4) random_commit(-1);
        marker_commit(`INST_START, 1'b0);
        repeat (N_RANDOM) random_commit(-1);
        marker_commit(`INST_STOP, 1'b0);
        for (int f = 0; f < `ERR_W; f++) begin
            random_commit(f);
            repeat (2) random_commit(-1);
        end
        marker_commit(`INST_HALT_JAL, 1'b1);
        @(negedge itf);
        valid = 1'b0;
        repeat (4) @(negedge itf);
        if (!halt || !measure_done) begin
            $display("Stream ended without halt or without a finished measurement window");
            other_errors++;
        end
        $display("Window: %0d instructions in %0d cycles, IPC x1000 = %0d",
                 inst_count, cycle_count, (inst_count * 1000) / cycle_count);
        $display("Errors: %0d mismatches, %0d other", error_count, other_errors);
        if (error_count + other_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT) begin
            @(posedge itf);
            cycles++;
        end
        other_errors++;
        $display("Timeout: the stimulus was still running after %0d cycles", TIMEOUT);
        $display("Errors: %0d mismatches, %0d other", error_count, other_errors);
        $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+design
design/rvfi_pkg.sv
design/mon_pkg.sv
design/commit_checker.sv
design/run_control.sv
design/trace_encoder.sv
design/commit_monitor.sv
bench/commit_monitor_assertions.sv
bench/commit_monitor_checker.sv
bench/commit_monitor_tb.sv

// File: run.sh
#!/bin/sh
# Build and run with Verilator, then scan the log for the result
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module commit_monitor_tb \
    -o sim_commit_monitor && ./obj_dir/sim_commit_monitor > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "TEST PASS" sim.log && ! grep -q "TEST FAIL" sim.log || exit 1
